// File: hdl/remap_mem_defines.svh
`ifndef REMAP_MEM_DEFINES_SVH
`define REMAP_MEM_DEFINES_SVH

// data word width
`define REMAP_WIDTH 16

// virtual banks seen by the user, plus one spare physical bank
`define REMAP_NUMVBNK 4
`define REMAP_NUMPBNK 5
`define REMAP_NUMROW 16

`define REMAP_BITVBNK 2
`define REMAP_BITPBNK 3
`define REMAP_BITROW 4

// map lookup plus bank read
`define REMAP_RD_LAT 2

`endif

// File: hdl/remap_mem_pkg.sv
`default_nettype none

`include "remap_mem_defines.svh"

package remap_mem_pkg;

  // virtual bank in the upper bits, row in the lower bits
  typedef logic [`REMAP_BITVBNK+`REMAP_BITROW-1:0] addr_t;

  typedef logic [`REMAP_BITVBNK-1:0] vbank_t;
  typedef logic [`REMAP_BITPBNK-1:0] pbank_t;
  typedef logic [`REMAP_BITROW-1:0] row_t;
  typedef logic [`REMAP_WIDTH-1:0] data_t;

  // physical bank followed by row
  typedef logic [`REMAP_BITPBNK+`REMAP_BITROW-1:0] padr_t;

  // one map entry per row
  typedef struct packed {
    pbank_t spare;
    pbank_t [`REMAP_NUMVBNK-1:0] vmap;
  } map_row_t;

endpackage

`default_nettype wire

// File: hdl/bank_cmd_pkg.sv
`default_nettype none

package bank_cmd_pkg;

  // single access per bank per cycle
  typedef enum logic [1:0] {
    CMD_NOP,
    CMD_READ,
    CMD_WRITE
  } bank_cmd_e;

endpackage

`default_nettype wire

// File: hdl/phys_bank.sv
`default_nettype none

`include "remap_mem_defines.svh"

module phys_bank (
  input  wire logic                 clk,
  input  wire bank_cmd_pkg::bank_cmd_e cmd,
  input  wire remap_mem_pkg::row_t  row,
  input  wire remap_mem_pkg::data_t wdata,
  output remap_mem_pkg::data_t      dout
);

  // single-ported storage, one access per cycle
  remap_mem_pkg::data_t mem [`REMAP_NUMROW];

  always_ff @(posedge clk) begin
    case (cmd)
      bank_cmd_pkg::CMD_WRITE: begin
        mem[row] <= wdata;
      end
      bank_cmd_pkg::CMD_READ: begin
        // registered read data
        dout <= mem[row];
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/read_collect.sv
`default_nettype none

`include "remap_mem_defines.svh"

module read_collect (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  rd_pend,
  input  wire remap_mem_pkg::pbank_t rd_pbank,
  input  wire remap_mem_pkg::row_t   rd_row,
  input  wire remap_mem_pkg::data_t  bank_dout [`REMAP_NUMPBNK],
  output logic                       rd_vld,
  output remap_mem_pkg::data_t       rd_dout,
  output remap_mem_pkg::padr_t       rd_padr
);

  logic                  vld_q;
  remap_mem_pkg::pbank_t pbank_q;
  remap_mem_pkg::row_t   row_q;

  // line up with the bank's registered dout
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= rd_pend;
    end
  end

  always_ff @(posedge clk) begin
    pbank_q <= rd_pbank;
    row_q   <= rd_row;
  end

  assign rd_vld  = vld_q;
  assign rd_padr = {pbank_q, row_q};

  // pick the answering bank
  always_comb begin
    rd_dout = '0;
    for (int b = 0; b < `REMAP_NUMPBNK; b++) begin
      if (pbank_q == remap_mem_pkg::pbank_t'(b)) begin
        rd_dout = bank_dout[b];
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/remap_ctrl.sv
`default_nettype none

`include "remap_mem_defines.svh"

module remap_ctrl (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   read,
  input  wire remap_mem_pkg::addr_t   raddr,
  input  wire logic                   write,
  input  wire remap_mem_pkg::addr_t   waddr,
  input  wire remap_mem_pkg::data_t   wdata,
  output bank_cmd_pkg::bank_cmd_e     bank_cmd [`REMAP_NUMPBNK],
  output remap_mem_pkg::row_t         bank_row [`REMAP_NUMPBNK],
  output remap_mem_pkg::data_t        bank_wdata,
  output logic                        rd_pend,
  output remap_mem_pkg::pbank_t       rd_pbank,
  output remap_mem_pkg::row_t         rd_row
);

  // identity map, spare is the last physical bank
  function automatic remap_mem_pkg::map_row_t init_row();
    remap_mem_pkg::map_row_t entry;
    for (int v = 0; v < `REMAP_NUMVBNK; v++) begin
      entry.vmap[v] = remap_mem_pkg::pbank_t'(v);
    end
    entry.spare = remap_mem_pkg::pbank_t'(`REMAP_NUMVBNK);
    return entry;
  endfunction

  remap_mem_pkg::map_row_t map_tbl [`REMAP_NUMROW];

  remap_mem_pkg::vbank_t r_vbank;
  remap_mem_pkg::row_t   r_row;
  remap_mem_pkg::vbank_t w_vbank;
  remap_mem_pkg::row_t   w_row;

  remap_mem_pkg::pbank_t   r_pbank;
  remap_mem_pkg::map_row_t w_entry;
  remap_mem_pkg::pbank_t   w_home;
  remap_mem_pkg::pbank_t   w_pbank;
  logic                    collide;

  // address split
  assign r_vbank = raddr[`REMAP_BITROW +: `REMAP_BITVBNK];
  assign r_row   = raddr[`REMAP_BITROW-1:0];
  assign w_vbank = waddr[`REMAP_BITROW +: `REMAP_BITVBNK];
  assign w_row   = waddr[`REMAP_BITROW-1:0];

  // lookups use the map as it stood before this edge
  assign r_pbank = map_tbl[r_row].vmap[r_vbank];
  assign w_entry = map_tbl[w_row];
  assign w_home  = w_entry.vmap[w_vbank];

  // write would hit the bank the read is using, so move it to the spare
  assign collide = read && write && (w_home == r_pbank);
  assign w_pbank = collide ? w_entry.spare : w_home;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < `REMAP_NUMROW; r++) begin
        map_tbl[r] <= init_row();
      end
    end else if (collide) begin
      // displaced bank becomes the new spare
      map_tbl[w_row].vmap[w_vbank] <= w_entry.spare;
      map_tbl[w_row].spare         <= w_home;
    end
  end

  // one command per bank, issued the cycle after the request
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < `REMAP_NUMPBNK; b++) begin
        bank_cmd[b] <= bank_cmd_pkg::CMD_NOP;
      end
    end else begin
      for (int b = 0; b < `REMAP_NUMPBNK; b++) begin
        if (write && (w_pbank == remap_mem_pkg::pbank_t'(b))) begin
          bank_cmd[b] <= bank_cmd_pkg::CMD_WRITE;
        end else if (read && (r_pbank == remap_mem_pkg::pbank_t'(b))) begin
          bank_cmd[b] <= bank_cmd_pkg::CMD_READ;
        end else begin
          bank_cmd[b] <= bank_cmd_pkg::CMD_NOP;
        end
      end
    end
  end

  // row and data follow the command
  always_ff @(posedge clk) begin
    for (int b = 0; b < `REMAP_NUMPBNK; b++) begin
      if (write && (w_pbank == remap_mem_pkg::pbank_t'(b))) begin
        bank_row[b] <= w_row;
      end else begin
        bank_row[b] <= r_row;
      end
    end
    bank_wdata <= wdata;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= read;
    end
  end

  // read bank and row handed on to the collector
  always_ff @(posedge clk) begin
    rd_pbank <= r_pbank;
    rd_row   <= r_row;
  end

endmodule

`default_nettype wire

// File: hdl/remap_mem.sv
`default_nettype none

`include "remap_mem_defines.svh"

module remap_mem (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 read,
  input  wire remap_mem_pkg::addr_t raddr,
  input  wire logic                 write,
  input  wire remap_mem_pkg::addr_t waddr,
  input  wire remap_mem_pkg::data_t wdata,
  output logic                      rd_vld,
  output remap_mem_pkg::data_t      rd_dout,
  output remap_mem_pkg::padr_t      rd_padr
);

  bank_cmd_pkg::bank_cmd_e bank_cmd [`REMAP_NUMPBNK];
  remap_mem_pkg::row_t     bank_row [`REMAP_NUMPBNK];
  remap_mem_pkg::data_t    bank_wdata;
  remap_mem_pkg::data_t    bank_dout [`REMAP_NUMPBNK];

  logic                  rd_pend;
  remap_mem_pkg::pbank_t rd_pbank;
  remap_mem_pkg::row_t   rd_row;

  remap_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .read       (read),
    .raddr      (raddr),
    .write      (write),
    .waddr      (waddr),
    .wdata      (wdata),
    .bank_cmd   (bank_cmd),
    .bank_row   (bank_row),
    .bank_wdata (bank_wdata),
    .rd_pend    (rd_pend),
    .rd_pbank   (rd_pbank),
    .rd_row     (rd_row)
  );

  // virtual banks plus the spare
  for (genvar b = 0; b < `REMAP_NUMPBNK; b++) begin : g_bank
    phys_bank u_bank (
      .clk   (clk),
      .cmd   (bank_cmd[b]),
      .row   (bank_row[b]),
      .wdata (bank_wdata),
      .dout  (bank_dout[b])
    );
  end

  read_collect u_collect (
    .clk       (clk),
    .rst       (rst),
    .rd_pend   (rd_pend),
    .rd_pbank  (rd_pbank),
    .rd_row    (rd_row),
    .bank_dout (bank_dout),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rd_padr   (rd_padr)
  );

endmodule

`default_nettype wire

// File: bench/remap_mem_properties.sv
`default_nettype none

`include "remap_mem_defines.svh"

module remap_mem_properties (
  input wire logic                    clk,
  input wire logic                    rst,
  input wire logic                    read,
  input wire logic                    write,
  input wire remap_mem_pkg::pbank_t   r_pbank,
  input wire remap_mem_pkg::pbank_t   w_pbank,
  input wire remap_mem_pkg::map_row_t w_entry,
  input wire logic                    rd_pend
);

  logic spare_free;

  // spare of the written row must not alias any mapped bank
  always_comb begin
    spare_free = 1'b1;
    for (int v = 0; v < `REMAP_NUMVBNK; v++) begin
      if (w_entry.vmap[v] == w_entry.spare) begin
        spare_free = 1'b0;
      end
    end
  end

  bank_access_unique: assert property (@(posedge clk) disable iff (rst)
    (read && write) |-> (w_pbank != r_pbank))
    else $error("read and write both sent to physical bank %0d", r_pbank);

  spare_unmapped: assert property (@(posedge clk) disable iff (rst)
    write |-> spare_free)
    else $error("spare bank %0d is also mapped in the written row", w_entry.spare);

  rd_pend_set: assert property (@(posedge clk) disable iff (rst)
    read |=> rd_pend)
    else $error("rd_pend did not follow a read");

  rd_pend_clear: assert property (@(posedge clk) disable iff (rst)
    !read |=> !rd_pend)
    else $error("rd_pend raised without a read");

endmodule

bind remap_ctrl remap_mem_properties u_props (
  .clk     (clk),
  .rst     (rst),
  .read    (read),
  .write   (write),
  .r_pbank (r_pbank),
  .w_pbank (w_pbank),
  .w_entry (w_entry),
  .rd_pend (rd_pend)
);

`default_nettype wire

// File: bench/remap_mem_tb.sv
`default_nettype none

`include "remap_mem_defines.svh"

module remap_mem_tb;

  localparam int MAX_OPS   = 320;
  localparam int NUM_TESTS = 5;
  localparam int NUM_ADDR  = `REMAP_NUMVBNK * `REMAP_NUMROW;

  // one table row per cycle with expected values from the model
  typedef struct packed {
    logic                 rd;
    remap_mem_pkg::addr_t raddr;
    logic                 wr;
    remap_mem_pkg::addr_t waddr;
    remap_mem_pkg::data_t wdata;
    int                   test;
    remap_mem_pkg::data_t exp_dout;
    remap_mem_pkg::padr_t exp_padr;
  } op_t;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 read;
  remap_mem_pkg::addr_t raddr;
  logic                 write;
  remap_mem_pkg::addr_t waddr;
  remap_mem_pkg::data_t wdata;
  logic                 rd_vld;
  remap_mem_pkg::data_t rd_dout;
  remap_mem_pkg::padr_t rd_padr;

  op_t         ops [MAX_OPS];
  int          n_ops;
  logic [31:0] lcg_state = 32'h1dc;
  int          cycles = 0;
  int          cycle_limit;
  int          n_checks = 0;
  int          n_errors = 0;
  int          test_checks = 0;
  int          test_errors = 0;
  string       test_name [NUM_TESTS];

  // reference map and bank contents
  remap_mem_pkg::pbank_t ref_vmap [`REMAP_NUMROW][`REMAP_NUMVBNK];
  remap_mem_pkg::pbank_t ref_spare [`REMAP_NUMROW];
  remap_mem_pkg::data_t  ref_mem [`REMAP_NUMPBNK][`REMAP_NUMROW];

  remap_mem u_dut (
    .clk     (clk),
    .rst     (rst),
    .read    (read),
    .raddr   (raddr),
    .write   (write),
    .waddr   (waddr),
    .wdata   (wdata),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_padr (rd_padr)
  );

  always #2 clk = ~clk;

  function automatic remap_mem_pkg::data_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  task automatic add_op(input logic r_en, input remap_mem_pkg::addr_t r_a, input logic w_en,
                        input remap_mem_pkg::addr_t w_a, input remap_mem_pkg::data_t w_d,
                        input int t);
    ops[n_ops].rd       = r_en;
    ops[n_ops].raddr    = r_a;
    ops[n_ops].wr       = w_en;
    ops[n_ops].waddr    = w_a;
    ops[n_ops].wdata    = w_d;
    ops[n_ops].test     = t;
    ops[n_ops].exp_dout = '0;
    ops[n_ops].exp_padr = '0;
    n_ops++;
  endtask

  task automatic build_table();
    remap_mem_pkg::data_t r;
    n_ops = 0;
    // fill every address and read each one back
    for (int a = 0; a < NUM_ADDR; a++) begin
      add_op(1'b0, '0, 1'b1, remap_mem_pkg::addr_t'(a), next_rand(), 0);
    end
    for (int a = 0; a < NUM_ADDR; a++) begin
      add_op(1'b1, remap_mem_pkg::addr_t'(a), 1'b0, '0, '0, 0);
    end
    // gaps and a burst of back-to-back reads
    add_op(1'b1, 6'h21, 1'b0, '0, '0, 1);
    add_op(1'b0, '0, 1'b0, '0, '0, 1);
    add_op(1'b1, 6'h12, 1'b0, '0, '0, 1);
    add_op(1'b1, 6'h33, 1'b0, '0, '0, 1);
    add_op(1'b1, 6'h04, 1'b0, '0, '0, 1);
    add_op(1'b0, '0, 1'b0, '0, '0, 1);
    add_op(1'b0, '0, 1'b0, '0, '0, 1);
    add_op(1'b1, 6'h3f, 1'b0, '0, '0, 1);
    // read and write share a physical bank so the write moves to the spare
    add_op(1'b1, 6'h03, 1'b1, 6'h05, next_rand(), 2);
    add_op(1'b1, 6'h05, 1'b0, '0, '0, 2);
    add_op(1'b1, 6'h03, 1'b0, '0, '0, 2);
    add_op(1'b1, 6'h27, 1'b1, 6'h2a, next_rand(), 2);
    add_op(1'b0, '0, 1'b0, '0, '0, 2);
    add_op(1'b1, 6'h2a, 1'b0, '0, '0, 2);
    // old data first and new data one cycle later
    add_op(1'b1, 6'h17, 1'b1, 6'h17, next_rand(), 3);
    add_op(1'b1, 6'h17, 1'b0, '0, '0, 3);
    add_op(1'b0, '0, 1'b0, '0, '0, 3);
    for (int i = 0; i < 160; i++) begin
      r = next_rand();
      add_op(r[0], r[7:2], r[1], r[13:8], next_rand(), 4);
    end
  endtask

  task automatic run_model();
    remap_mem_pkg::vbank_t rv;
    remap_mem_pkg::vbank_t wv;
    remap_mem_pkg::row_t   rr;
    remap_mem_pkg::row_t   wrow;
    remap_mem_pkg::pbank_t rp;
    remap_mem_pkg::pbank_t wp;
    for (int r = 0; r < `REMAP_NUMROW; r++) begin
      for (int v = 0; v < `REMAP_NUMVBNK; v++) begin
        ref_vmap[r][v] = remap_mem_pkg::pbank_t'(v);
      end
      ref_spare[r] = remap_mem_pkg::pbank_t'(`REMAP_NUMVBNK);
    end
    for (int p = 0; p < `REMAP_NUMPBNK; p++) begin
      for (int r = 0; r < `REMAP_NUMROW; r++) begin
        ref_mem[p][r] = '0;
      end
    end
    for (int i = 0; i < n_ops; i++) begin
      rv   = ops[i].raddr[`REMAP_BITROW +: `REMAP_BITVBNK];
      rr   = ops[i].raddr[`REMAP_BITROW-1:0];
      wv   = ops[i].waddr[`REMAP_BITROW +: `REMAP_BITVBNK];
      wrow = ops[i].waddr[`REMAP_BITROW-1:0];
      rp   = ref_vmap[rr][rv];
      wp   = ref_vmap[wrow][wv];
      // read sees the contents before this cycle's write
      if (ops[i].rd) begin
        ops[i].exp_dout = ref_mem[rp][rr];
        ops[i].exp_padr = {rp, rr};
      end
      if (ops[i].wr) begin
        if (ops[i].rd && (wp == rp)) begin
          ref_vmap[wrow][wv] = ref_spare[wrow];
          ref_spare[wrow]    = wp;
          wp                 = ref_vmap[wrow][wv];
        end
        ref_mem[wp][wrow] = ops[i].wdata;
      end
    end
  endtask

  // nothing has been read yet, so the valid flag must stay low
  task automatic check_idle();
    if (rd_vld !== 1'b0) begin
      $display("Error at %0t: rd_vld expected 0 got %b", $time, rd_vld);
      n_errors++;
      test_errors++;
    end
  endtask

  task automatic check_row(input int k);
    n_checks++;
    test_checks++;
    if (rd_vld !== ops[k].rd) begin
      $display("Error at %0t: rd_vld expected %b got %b", $time, ops[k].rd, rd_vld);
      n_errors++;
      test_errors++;
    end
    if (ops[k].rd && (rd_dout !== ops[k].exp_dout)) begin
      $display("Error at %0t: rd_dout expected %h got %h", $time, ops[k].exp_dout, rd_dout);
      n_errors++;
      test_errors++;
    end
    if (ops[k].rd && (rd_padr !== ops[k].exp_padr)) begin
      $display("Error at %0t: rd_padr expected %h got %h", $time, ops[k].exp_padr, rd_padr);
      n_errors++;
      test_errors++;
    end
    if ((k == n_ops - 1) || (ops[k+1].test != ops[k].test)) begin
      $display("test %0d %s: %0d rows, %0d errors", ops[k].test, test_name[ops[k].test],
               test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: run did not end within %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    rst   = 1'b1;
    read  = 1'b0;
    raddr = '0;
    write = 1'b0;
    waddr = '0;
    wdata = '0;
    test_name[0] = "fill and read back";
    test_name[1] = "read latency";
    test_name[2] = "collision redirect";
    test_name[3] = "same address read and write";
    test_name[4] = "random mix";
    build_table();
    run_model();
    cycle_limit = n_ops + 16 + 40;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    // a row reaches the outputs one read latency after it is driven
    for (int i = 0; i < n_ops + `REMAP_RD_LAT; i++) begin
      @(posedge clk);
      if (i < n_ops) begin
        read  <= ops[i].rd;
        raddr <= ops[i].raddr;
        write <= ops[i].wr;
        waddr <= ops[i].waddr;
        wdata <= ops[i].wdata;
      end else begin
        read  <= 1'b0;
        write <= 1'b0;
      end
      @(negedge clk);
      if (i >= `REMAP_RD_LAT) begin
        check_row(i - `REMAP_RD_LAT);
      end else begin
        check_idle();
      end
    end
    $display("%0d rows checked, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: remap_mem.f
+incdir+hdl
hdl/remap_mem_pkg.sv
hdl/bank_cmd_pkg.sv
hdl/phys_bank.sv
hdl/read_collect.sv
hdl/remap_ctrl.sv
hdl/remap_mem.sv
bench/remap_mem_properties.sv
bench/remap_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module remap_mem_tb -f remap_mem.f -o remap_mem_sim \
  && ./obj_dir/remap_mem_sim > sim.log 2>&1 \
  || echo "Checks failed" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0
